/* isa_pkg.sv */
package isa_pkg;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    // register-register ops; shift-immediate ops keep ui5 in the rk slot
    typedef struct packed {
        logic [16:0] op;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] imm;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_2ri12_t;

    // b/bl take {rj, rd, offs} as a 26-bit offset
    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] offs;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]  op;
        logic [19:0] imm;
        reg_idx_t    rd;
    } fmt_1ri20_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_2ri16_t fmt_2ri16;
        fmt_1ri20_t fmt_1ri20;
    } inst_u;

    // inst[31:15]
    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_SLTU   = 17'h00025;
    localparam logic [16:0] OP_NOR    = 17'h00028;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [16:0] OP_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP_SRA_W  = 17'h00030;
    localparam logic [16:0] OP_SLLI_W = 17'h00081;
    localparam logic [16:0] OP_SRLI_W = 17'h00089;
    localparam logic [16:0] OP_SRAI_W = 17'h00091;

    // inst[31:22]
    localparam logic [9:0] OP_SLTI   = 10'h008;
    localparam logic [9:0] OP_SLTUI  = 10'h009;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_XORI   = 10'h00f;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;

    // inst[31:26]
    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;
    localparam logic [5:0] OP_BLT  = 6'h18;
    localparam logic [5:0] OP_BGE  = 6'h19;
    localparam logic [5:0] OP_BLTU = 6'h1a;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    // inst[31:25]
    localparam logic [6:0] OP_LU12I_W   = 7'h0a;
    localparam logic [6:0] OP_PCADDU12I = 7'h0e;

endpackage

/* pipe_pkg.sv */
package pipe_pkg;

    // one-hot, bit positions below
    typedef logic [11:0] alu_op_t;

    localparam int ALU_ADD  = 0;   // also ld/st address, jirl/bl link, pcaddu12i
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef logic [1:0] imm_kind_t;

    localparam imm_kind_t IMM_SI12 = 2'd0;
    localparam imm_kind_t IMM_UI12 = 2'd1;
    localparam imm_kind_t IMM_HI20 = 2'd2;   // imm20 << 12
    localparam imm_kind_t IMM_FOUR = 2'd3;   // return address offset

endpackage

/* id_ctrl.sv */
module id_ctrl (
    input  logic           clk,
    input  logic           resetn,
    input  logic           if_valid,
    input  isa_pkg::word_t if_inst,
    input  isa_pkg::word_t if_pc,
    input  logic           ex_allowin,
    input  logic           stall,
    input  logic           branch_cond,
    output logic           id_allowin,
    output logic           id_to_ex_valid,
    output logic           id_valid,
    output isa_pkg::inst_u inst,
    output isa_pkg::word_t pc,
    output logic           br_taken
);
    logic ready_go;

    assign ready_go       = ~stall;
    assign id_to_ex_valid = id_valid & ready_go;
    assign id_allowin     = ~id_valid | (ready_go & ex_allowin);
    assign br_taken       = branch_cond & id_to_ex_valid & ex_allowin;  // only on handoff

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;  // wrong-path fetch dropped
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            inst <= if_inst;
            pc   <= if_pc;
        end
    end

    // fetch offers a known word whenever it can be captured
    a_fetch_known: assert property (@(posedge clk) disable iff (!resetn)
        (if_valid && id_allowin) |-> !$isunknown({if_inst, if_pc}));

endmodule

/* inst_decoder.sv */
module inst_decoder (
    input  isa_pkg::inst_u    inst,
    input  isa_pkg::word_t    pc,
    input  logic              id_valid,
    output pipe_pkg::alu_op_t alu_op,
    output isa_pkg::word_t    imm,
    output logic              src1_is_pc,
    output logic              src2_is_imm,
    output isa_pkg::reg_idx_t raddr1,
    output isa_pkg::reg_idx_t raddr2,
    output logic              need_r1,
    output logic              need_r2,
    output logic              rf_we,
    output isa_pkg::reg_idx_t rf_waddr,
    output logic              res_from_mem,
    output logic              mem_we,
    output logic              is_branch,
    output logic              is_jirl,
    output logic              is_cond_branch,
    output logic [2:0]        branch_kind
);
    import isa_pkg::*;
    import pipe_pkg::*;

    wire inst_add_w     = inst.fmt_3r.op == OP_ADD_W;
    wire inst_sub_w     = inst.fmt_3r.op == OP_SUB_W;
    wire inst_slt       = inst.fmt_3r.op == OP_SLT;
    wire inst_sltu      = inst.fmt_3r.op == OP_SLTU;
    wire inst_nor       = inst.fmt_3r.op == OP_NOR;
    wire inst_and       = inst.fmt_3r.op == OP_AND;
    wire inst_or        = inst.fmt_3r.op == OP_OR;
    wire inst_xor       = inst.fmt_3r.op == OP_XOR;
    wire inst_sll_w     = inst.fmt_3r.op == OP_SLL_W;
    wire inst_srl_w     = inst.fmt_3r.op == OP_SRL_W;
    wire inst_sra_w     = inst.fmt_3r.op == OP_SRA_W;
    wire inst_slli_w    = inst.fmt_3r.op == OP_SLLI_W;
    wire inst_srli_w    = inst.fmt_3r.op == OP_SRLI_W;
    wire inst_srai_w    = inst.fmt_3r.op == OP_SRAI_W;
    wire inst_addi_w    = inst.fmt_2ri12.op == OP_ADDI_W;
    wire inst_slti      = inst.fmt_2ri12.op == OP_SLTI;
    wire inst_sltui     = inst.fmt_2ri12.op == OP_SLTUI;
    wire inst_andi      = inst.fmt_2ri12.op == OP_ANDI;
    wire inst_ori       = inst.fmt_2ri12.op == OP_ORI;
    wire inst_xori      = inst.fmt_2ri12.op == OP_XORI;
    wire inst_ld_w      = inst.fmt_2ri12.op == OP_LD_W;
    wire inst_st_w      = inst.fmt_2ri12.op == OP_ST_W;
    wire inst_jirl      = inst.fmt_2ri16.op == OP_JIRL;
    wire inst_b         = inst.fmt_2ri16.op == OP_B;
    wire inst_bl        = inst.fmt_2ri16.op == OP_BL;
    wire inst_beq       = inst.fmt_2ri16.op == OP_BEQ;
    wire inst_bne       = inst.fmt_2ri16.op == OP_BNE;
    wire inst_blt       = inst.fmt_2ri16.op == OP_BLT;
    wire inst_bge       = inst.fmt_2ri16.op == OP_BGE;
    wire inst_bltu      = inst.fmt_2ri16.op == OP_BLTU;
    wire inst_bgeu      = inst.fmt_2ri16.op == OP_BGEU;
    wire inst_lu12i_w   = inst.fmt_1ri20.op == OP_LU12I_W;
    wire inst_pcaddu12i = inst.fmt_1ri20.op == OP_PCADDU12I;

    wire is_rr    = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                  | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    wire is_ri    = inst_addi_w | inst_slti | inst_sltui | inst_andi | inst_ori | inst_xori
                  | inst_slli_w | inst_srli_w | inst_srai_w;
    wire is_u20   = inst_lu12i_w | inst_pcaddu12i;
    wire is_link  = inst_jirl | inst_bl;
    wire fetch_ok = id_valid & ~|pc[1:0];  // misaligned fetch has no side effects

    imm_kind_t imm_kind;

    assign alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w | is_link
                            | inst_pcaddu12i;
    assign alu_op[ALU_SUB]  = inst_sub_w;
    assign alu_op[ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
    assign alu_op[ALU_AND]  = inst_and | inst_andi;
    assign alu_op[ALU_NOR]  = inst_nor;
    assign alu_op[ALU_OR]   = inst_or | inst_ori;
    assign alu_op[ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
    assign alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
    assign alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
    assign alu_op[ALU_LUI]  = inst_lu12i_w;

    always_comb begin
        if (is_link)
            imm_kind = IMM_FOUR;
        else if (is_u20)
            imm_kind = IMM_HI20;
        else if (inst_andi | inst_ori | inst_xori)
            imm_kind = IMM_UI12;
        else
            imm_kind = IMM_SI12;  // ui5 of shifts sits in the low bits
    end

    always_comb begin
        case (imm_kind)
            IMM_FOUR: imm = 32'd4;
            IMM_HI20: imm = {inst.fmt_1ri20.imm, 12'b0};
            IMM_UI12: imm = {20'b0, inst.fmt_2ri12.imm};
            default:  imm = {{20{inst.fmt_2ri12.imm[11]}}, inst.fmt_2ri12.imm};
        endcase
    end

    assign is_cond_branch = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    assign is_jirl        = inst_jirl;
    assign is_branch      = is_cond_branch | inst_b | is_link;

    // [2:1] compare: 00 eq, 01 signed lt, 10 unsigned lt; [0] inverts
    assign branch_kind[2] = inst_bltu | inst_bgeu;
    assign branch_kind[1] = inst_blt | inst_bge;
    assign branch_kind[0] = inst_bne | inst_bge | inst_bgeu;

    assign src1_is_pc  = is_link | inst_pcaddu12i;
    assign src2_is_imm = is_ri | inst_ld_w | inst_st_w | is_u20 | is_link;

    assign raddr1  = inst.fmt_3r.rj;
    assign raddr2  = (inst_st_w | is_cond_branch) ? inst.fmt_3r.rd : inst.fmt_3r.rk;
    assign need_r1 = is_rr | is_ri | inst_ld_w | inst_st_w | inst_jirl | is_cond_branch;
    assign need_r2 = is_rr | inst_st_w | is_cond_branch;

    assign rf_we        = fetch_ok & (is_rr | is_ri | is_u20 | inst_ld_w | is_link);
    assign rf_waddr     = inst_bl ? 5'd1 : inst.fmt_3r.rd;
    assign res_from_mem = fetch_ok & inst_ld_w;
    assign mem_we       = fetch_ok & inst_st_w;

endmodule

/* regfile.sv */
module regfile (
    input  logic              clk,
    input  isa_pkg::reg_idx_t raddr1,
    input  isa_pkg::reg_idx_t raddr2,
    input  logic              we,
    input  isa_pkg::reg_idx_t waddr,
    input  isa_pkg::word_t    wdata,
    output isa_pkg::word_t    rdata1,
    output isa_pkg::word_t    rdata2
);
    import isa_pkg::*;

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 hardwired, same-cycle write comes in through WB forwarding
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

    a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr))
        else $error("regfile write with unknown address");

endmodule

/* operand_forward.sv */
module operand_forward (
    input  isa_pkg::reg_idx_t raddr1,
    input  isa_pkg::reg_idx_t raddr2,
    input  logic              need_r1,
    input  logic              need_r2,
    input  isa_pkg::word_t    rdata1,
    input  isa_pkg::word_t    rdata2,
    input  logic              ex_rf_we,
    input  isa_pkg::reg_idx_t ex_rf_waddr,
    input  isa_pkg::word_t    ex_rf_wdata,
    input  logic              mem_rf_we,
    input  isa_pkg::reg_idx_t mem_rf_waddr,
    input  isa_pkg::word_t    mem_rf_wdata,
    input  logic              wb_rf_we,
    input  isa_pkg::reg_idx_t wb_rf_waddr,
    input  isa_pkg::word_t    wb_rf_wdata,
    input  logic              ex_res_from_mem,
    input  logic              src1_is_pc,
    input  logic              src2_is_imm,
    input  isa_pkg::word_t    pc,
    input  isa_pkg::word_t    imm,
    output isa_pkg::word_t    rj_value,
    output isa_pkg::word_t    rkd_value,
    output isa_pkg::word_t    alu_src1,
    output isa_pkg::word_t    alu_src2,
    output logic              stall
);
    import isa_pkg::*;

    // source needed, nonzero, and written by that stage
    function automatic logic hit(reg_idx_t src, logic need, logic we, reg_idx_t dst);
        return need && src != '0 && we && src == dst;
    endfunction

    wire r1_ex  = hit(raddr1, need_r1, ex_rf_we, ex_rf_waddr);
    wire r1_mem = hit(raddr1, need_r1, mem_rf_we, mem_rf_waddr);
    wire r1_wb  = hit(raddr1, need_r1, wb_rf_we, wb_rf_waddr);
    wire r2_ex  = hit(raddr2, need_r2, ex_rf_we, ex_rf_waddr);
    wire r2_mem = hit(raddr2, need_r2, mem_rf_we, mem_rf_waddr);
    wire r2_wb  = hit(raddr2, need_r2, wb_rf_we, wb_rf_waddr);

    // youngest producer wins
    assign rj_value  = r1_ex  ? ex_rf_wdata  :
                       r1_mem ? mem_rf_wdata :
                       r1_wb  ? wb_rf_wdata  : rdata1;
    assign rkd_value = r2_ex  ? ex_rf_wdata  :
                       r2_mem ? mem_rf_wdata :
                       r2_wb  ? wb_rf_wdata  : rdata2;

    assign stall = ex_res_from_mem & (r1_ex | r2_ex);  // load data not back yet

    assign alu_src1 = src1_is_pc  ? pc  : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

endmodule

/* branch_unit.sv */
module branch_unit (
    input  isa_pkg::inst_u inst,
    input  isa_pkg::word_t pc,
    input  isa_pkg::word_t rj_value,
    input  isa_pkg::word_t rkd_value,
    input  logic           is_branch,
    input  logic           is_jirl,
    input  logic           is_cond_branch,
    input  logic [2:0]     branch_kind,
    output logic           branch_cond,
    output isa_pkg::word_t br_target
);
    import isa_pkg::*;

    logic  cmp_true;
    word_t offs16;
    word_t offs26;

    assign offs16 = {{14{inst.fmt_2ri16.offs[15]}}, inst.fmt_2ri16.offs, 2'b00};
    assign offs26 = {{4{inst.fmt_2ri16.rj[4]}}, inst.fmt_2ri16.rj, inst.fmt_2ri16.rd,
                     inst.fmt_2ri16.offs, 2'b00};

    always_comb begin
        case (branch_kind[2:1])
            2'b00:   cmp_true = rj_value == rkd_value;
            2'b01:   cmp_true = $signed(rj_value) < $signed(rkd_value);
            default: cmp_true = rj_value < rkd_value;
        endcase
    end

    // b, bl, jirl unconditional
    assign branch_cond = is_branch & (~is_cond_branch | (cmp_true ^ branch_kind[0]));

    assign br_target = is_jirl        ? rj_value + offs16 :
                       is_cond_branch ? pc + offs16       : pc + offs26;

endmodule

/* id_stage.sv */
module id_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              if_valid,
    input  isa_pkg::word_t    if_inst,
    input  isa_pkg::word_t    if_pc,
    output logic              id_allowin,
    input  logic              ex_allowin,
    output logic              id_to_ex_valid,
    output pipe_pkg::alu_op_t alu_op,
    output isa_pkg::word_t    alu_src1,
    output isa_pkg::word_t    alu_src2,
    output logic              res_from_mem,
    output logic              mem_we,
    output logic              rf_we,
    output isa_pkg::reg_idx_t rf_waddr,
    output isa_pkg::word_t    store_data,
    output isa_pkg::word_t    pc_out,
    output logic              br_taken,
    output isa_pkg::word_t    br_target,
    input  logic              ex_rf_we,
    input  logic              ex_res_from_mem,
    input  isa_pkg::reg_idx_t ex_rf_waddr,
    input  isa_pkg::word_t    ex_rf_wdata,
    input  logic              mem_rf_we,
    input  isa_pkg::reg_idx_t mem_rf_waddr,
    input  isa_pkg::word_t    mem_rf_wdata,
    input  logic              wb_rf_we,
    input  isa_pkg::reg_idx_t wb_rf_waddr,
    input  isa_pkg::word_t    wb_rf_wdata
);
    import isa_pkg::*;

    logic       id_valid;
    logic       stall;
    logic       branch_cond;
    inst_u      inst;
    word_t      imm;
    word_t      rdata1;
    word_t      rdata2;
    word_t      rj_value;
    reg_idx_t   raddr1;
    reg_idx_t   raddr2;
    logic       need_r1;
    logic       need_r2;
    logic       src1_is_pc;
    logic       src2_is_imm;
    logic       is_branch;
    logic       is_jirl;
    logic       is_cond_branch;
    logic [2:0] branch_kind;

    id_ctrl u_ctrl (
        .clk(clk), .resetn(resetn), .if_valid(if_valid), .if_inst(if_inst), .if_pc(if_pc),
        .ex_allowin(ex_allowin), .stall(stall), .branch_cond(branch_cond),
        .id_allowin(id_allowin), .id_to_ex_valid(id_to_ex_valid), .id_valid(id_valid),
        .inst(inst), .pc(pc_out), .br_taken(br_taken)
    );

    inst_decoder u_dec (
        .inst(inst), .pc(pc_out), .id_valid(id_valid), .alu_op(alu_op), .imm(imm),
        .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm), .raddr1(raddr1), .raddr2(raddr2),
        .need_r1(need_r1), .need_r2(need_r2), .rf_we(rf_we), .rf_waddr(rf_waddr),
        .res_from_mem(res_from_mem), .mem_we(mem_we), .is_branch(is_branch),
        .is_jirl(is_jirl), .is_cond_branch(is_cond_branch), .branch_kind(branch_kind)
    );

    regfile u_rf (
        .clk(clk), .raddr1(raddr1), .raddr2(raddr2), .we(wb_rf_we), .waddr(wb_rf_waddr),
        .wdata(wb_rf_wdata), .rdata1(rdata1), .rdata2(rdata2)
    );

    operand_forward u_fwd (
        .raddr1(raddr1), .raddr2(raddr2), .need_r1(need_r1), .need_r2(need_r2),
        .rdata1(rdata1), .rdata2(rdata2),
        .ex_rf_we(ex_rf_we), .ex_rf_waddr(ex_rf_waddr), .ex_rf_wdata(ex_rf_wdata),
        .mem_rf_we(mem_rf_we), .mem_rf_waddr(mem_rf_waddr), .mem_rf_wdata(mem_rf_wdata),
        .wb_rf_we(wb_rf_we), .wb_rf_waddr(wb_rf_waddr), .wb_rf_wdata(wb_rf_wdata),
        .ex_res_from_mem(ex_res_from_mem), .src1_is_pc(src1_is_pc),
        .src2_is_imm(src2_is_imm), .pc(pc_out), .imm(imm),
        .rj_value(rj_value), .rkd_value(store_data),  // rkd doubles as store data
        .alu_src1(alu_src1), .alu_src2(alu_src2), .stall(stall)
    );

    branch_unit u_br (
        .inst(inst), .pc(pc_out), .rj_value(rj_value), .rkd_value(store_data),
        .is_branch(is_branch), .is_jirl(is_jirl), .is_cond_branch(is_cond_branch),
        .branch_kind(branch_kind), .branch_cond(branch_cond), .br_target(br_target)
    );

endmodule

/* tb_id_stage.sv */
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] EX_D  = 32'he1e2e3e4;
    localparam logic [31:0] MEM_D = 32'ha5a6a7a8;
    localparam logic [31:0] WB_D  = 32'hb9bab0b1;
    localparam logic [31:0] JUNK  = 32'h00101d8c;  // add.w r12,r12,r7

    // brk: 0 none, 1 eq, 2 ne, 3 lt, 4 ge, 5 ltu, 6 geu, 7 always
    // fwd: bit2 EX, bit1 MEM, bit0 WB, all aimed at the rj register
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [3:0]  alu_bit;  // 15 means no ALU op
        logic [1:0]  ikind;    // 0 si12, 1 ui12, 2 hi20, 3 four
        logic        s1pc;
        logic        s2imm;
        logic        need2;
        logic        we;
        logic [2:0]  fwd;
        logic        ex_load;
        logic        ex_allow;
        logic [2:0]  brk;
    } entry_t;

    logic clk, resetn, if_valid, id_allowin, ex_allowin, id_to_ex_valid;
    logic [31:0] if_inst, if_pc, alu_src1, alu_src2, store_data, pc_out, br_target;
    logic [11:0] alu_op;
    logic res_from_mem, mem_we, rf_we, br_taken;
    logic [4:0] rf_waddr, ex_rf_waddr, mem_rf_waddr, wb_rf_waddr;
    logic ex_rf_we, ex_res_from_mem, mem_rf_we, wb_rf_we;
    logic [31:0] ex_rf_wdata, mem_rf_wdata, wb_rf_wdata;

    entry_t      vectors[$];
    logic [31:0] regs[32];
    logic [31:0] lfsr_state = 32'd51;
    int          errors = 0;
    int          checks = 0;
    int          timeouts = 0;

    logic [11:0] exp_op;
    logic [31:0] exp_s1, exp_s2, exp_sd, exp_tgt;
    logic [4:0]  exp_wa;
    logic        exp_we, exp_mw, exp_rm, exp_valid, exp_allow, exp_bt;

    id_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk, rj, rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [9:0] op, input logic [11:0] imm,
                                              input logic [4:0] rj, rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri16(input logic [5:0] op, input logic [15:0] offs,
                                              input logic [4:0] rj, rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_1ri20(input logic [6:0] op, input logic [19:0] imm,
                                              input logic [4:0] rd);
        return {op, imm, rd};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        repeat (32) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic push(input logic [31:0] inst, input logic [3:0] alu_bit,
                        input logic [1:0] ikind, input logic s1pc, s2imm, need2, we,
                        input logic [2:0] fwd, input logic ex_load, ex_allow,
                        input logic [2:0] brk);
        entry_t e;
        e = '{inst, 32'h1c00_0100, alu_bit, ikind, s1pc, s2imm, need2, we, fwd,
              ex_load, ex_allow, brk};
        vectors.push_back(e);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_buses(input entry_t e);
        ex_rf_we        = e.fwd[2];
        ex_res_from_mem = e.ex_load;
        mem_rf_we       = e.fwd[1];
        wb_rf_we        = e.fwd[0];
        ex_rf_waddr     = e.inst[9:5];
        mem_rf_waddr    = e.inst[9:5];
        wb_rf_waddr     = e.inst[9:5];
        ex_rf_wdata     = EX_D;
        mem_rf_wdata    = MEM_D;
        wb_rf_wdata     = WB_D;
    endtask

    // expected outputs from the ISA rules and the register model
    task automatic model(input entry_t e);
        logic [4:0]  rj_i, r2_i;
        logic [31:0] v1, v2, imm;
        logic        st, ld, stall, cond;
        rj_i = e.inst[9:5];
        st   = e.inst[31:22] == 10'h0a6;
        ld   = e.inst[31:22] == 10'h0a2;
        r2_i = (st || (e.brk >= 1 && e.brk <= 6)) ? e.inst[4:0] : e.inst[14:10];
        if (e.fwd[0] && rj_i != 0)
            regs[rj_i] = WB_D;  // WB also lands in the register file
        v1 = regs[rj_i];
        v2 = regs[r2_i];
        if (rj_i != 0) begin
            if (e.fwd[1]) v1 = MEM_D;
            if (e.fwd[2]) v1 = EX_D;
            if (e.need2 && r2_i == rj_i) v2 = v1;
        end
        case (e.ikind)
            2'd0: imm = {{20{e.inst[21]}}, e.inst[21:10]};
            2'd1: imm = {20'b0, e.inst[21:10]};
            2'd2: imm = {e.inst[24:5], 12'b0};
            default: imm = 32'd4;
        endcase
        case (e.brk)
            3'd1: cond = v1 == v2;
            3'd2: cond = v1 != v2;
            3'd3: cond = $signed(v1) < $signed(v2);
            3'd4: cond = $signed(v1) >= $signed(v2);
            3'd5: cond = v1 < v2;
            3'd6: cond = v1 >= v2;
            3'd7: cond = 1'b1;
            default: cond = 1'b0;
        endcase
        stall     = e.ex_load && e.fwd[2] && rj_i != 0;
        exp_op    = 12'(32'd1 << e.alu_bit);
        exp_s1    = e.s1pc ? e.pc : v1;
        exp_s2    = e.s2imm ? imm : v2;
        exp_sd    = v2;
        exp_we    = e.we;
        exp_wa    = (e.inst[31:26] == 6'h15) ? 5'd1 : e.inst[4:0];
        exp_mw    = st;
        exp_rm    = ld;
        exp_valid = !stall;
        exp_allow = !stall && e.ex_allow;
        exp_bt    = cond && !stall && e.ex_allow;
        if (e.inst[31:26] == 6'h13)
            exp_tgt = v1 + {{14{e.inst[25]}}, e.inst[25:10], 2'b00};
        else if (e.brk >= 1 && e.brk <= 6)
            exp_tgt = e.pc + {{14{e.inst[25]}}, e.inst[25:10], 2'b00};
        else
            exp_tgt = e.pc + {{4{e.inst[9]}}, e.inst[9:0], e.inst[25:10], 2'b00};
    endtask

    task automatic compare_outputs(input entry_t e);
        check("id_to_ex_valid", id_to_ex_valid, exp_valid);
        check("id_allowin", id_allowin, exp_allow);
        check("br_taken", br_taken, exp_bt);
        check("alu_op", alu_op, exp_op);
        check("alu_src1", alu_src1, exp_s1);
        check("alu_src2", alu_src2, exp_s2);
        check("store_data", store_data, exp_sd);
        check("pc_out", pc_out, e.pc);
        if (exp_valid) begin
            check("rf_we", rf_we, exp_we);
            check("mem_we", mem_we, exp_mw);
            check("res_from_mem", res_from_mem, exp_rm);
        end
        if (exp_we)
            check("rf_waddr", rf_waddr, exp_wa);
        if (e.brk != 0)
            check("br_target", br_target, exp_tgt);
    endtask

    task automatic run_entry(input entry_t e);
        int n;
        @(posedge clk);
        #1;
        if_valid   = 1'b1;
        if_inst    = e.inst;
        if_pc      = e.pc;
        ex_allowin = 1'b1;
        n = 0;
        @(negedge clk);
        while (!id_allowin && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (n >= 20) begin
            $display("timeout: stage never accepted instruction %h", e.inst);
            timeouts++;
        end
        model(e);
        @(posedge clk);
        #1;
        if_inst    = JUNK;  // wrong-path offer
        if_pc      = e.pc + 4;
        ex_allowin = e.ex_allow;
        drive_buses(e);  // WB write lands one edge later, so only forwarding supplies it
        @(negedge clk);
        compare_outputs(e);
        if (!exp_valid) begin
            @(posedge clk);
            #1;
            ex_rf_we        = 1'b0;
            ex_res_from_mem = 1'b0;
            n = 0;
            @(negedge clk);
            while (!id_to_ex_valid && n < 20) begin
                @(negedge clk);
                n++;
            end
            if (n >= 20) begin
                $display("timeout: load-use stall did not end after EX was cleared");
                timeouts++;
            end
        end else if (exp_bt) begin
            @(negedge clk);
            check("id_to_ex_valid after flush", id_to_ex_valid, 1'b0);
        end else if (!e.ex_allow) begin
            @(negedge clk);
            compare_outputs(e);  // held steady
        end
        @(posedge clk);
        #1;
        if_valid   = 1'b0;
        ex_allowin = 1'b1;
        drive_buses('0);
        n = 0;
        @(negedge clk);
        while (id_to_ex_valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (n >= 20) begin
            $display("timeout: stage did not drain");
            timeouts++;
        end
    endtask

    initial begin
        resetn   = 1'b0;
        if_valid = 1'b0;
        if_inst  = '0;
        if_pc    = '0;
        ex_allowin = 1'b1;
        drive_buses('0);
        regs[0] = '0;
        repeat (8) @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        check("id_to_ex_valid", id_to_ex_valid, 1'b0);
        check("br_taken", br_taken, 1'b0);
        check("id_allowin", id_allowin, 1'b1);

        for (int r = 1; r < 32; r++) begin
            @(posedge clk);
            #1;
            rand_word(regs[r]);
            wb_rf_we    = 1'b1;
            wb_rf_waddr = 5'(r);
            wb_rf_wdata = regs[r];
        end
        @(posedge clk);
        #1 wb_rf_we = 1'b0;

        // register-register
        push(enc_3r(17'h20, 6, 5, 7), 0, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h22, 6, 5, 7), 1, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h24, 6, 5, 7), 2, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h25, 6, 5, 7), 3, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h29, 6, 5, 7), 4, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h28, 6, 5, 7), 5, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h2a, 6, 5, 7), 6, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h2b, 6, 5, 7), 7, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h2e, 6, 5, 7), 8, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h2f, 6, 5, 7), 9, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        push(enc_3r(17'h30, 6, 5, 7), 10, 0, 0, 0, 1, 1, 0, 0, 1, 0);
        // immediate forms
        push(enc_2ri12(10'h00a, 12'h83f, 5, 8), 0, 0, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_2ri12(10'h008, 12'h7f0, 5, 8), 2, 0, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_2ri12(10'h009, 12'hfff, 5, 8), 3, 0, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_2ri12(10'h00d, 12'hf0f, 5, 8), 4, 1, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_2ri12(10'h00e, 12'h9a5, 5, 8), 6, 1, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_2ri12(10'h00f, 12'h801, 5, 8), 7, 1, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_3r(17'h81, 3, 5, 8), 8, 0, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_3r(17'h89, 17, 5, 8), 9, 0, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_3r(17'h91, 31, 5, 8), 10, 0, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_1ri20(7'h0a, 20'hfedcb, 9), 11, 2, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_1ri20(7'h0e, 20'h80001, 9), 0, 2, 1, 1, 0, 1, 0, 0, 1, 0);
        push(enc_2ri12(10'h0a2, 12'hffc, 5, 10), 0, 0, 0, 1, 0, 1, 0, 0, 1, 0);
        push(enc_2ri12(10'h0a6, 12'h010, 5, 11), 0, 0, 0, 1, 1, 0, 0, 0, 1, 0);
        // forwarding priority, r0 source
        push(enc_3r(17'h20, 6, 5, 7), 0, 0, 0, 0, 1, 1, 7, 0, 1, 0);
        push(enc_3r(17'h20, 6, 5, 7), 0, 0, 0, 0, 1, 1, 3, 0, 1, 0);
        push(enc_3r(17'h20, 6, 5, 7), 0, 0, 0, 0, 1, 1, 1, 0, 1, 0);
        push(enc_3r(17'h20, 6, 0, 7), 0, 0, 0, 0, 1, 1, 7, 0, 1, 0);
        // load-use
        push(enc_3r(17'h20, 6, 5, 7), 0, 0, 0, 0, 1, 1, 4, 1, 1, 0);
        // branches and jumps
        push(enc_2ri16(6'h16, 16'h0010, 5, 5), 15, 0, 0, 0, 1, 0, 0, 0, 1, 1);
        push(enc_2ri16(6'h16, 16'hfff0, 5, 6), 15, 0, 0, 0, 1, 0, 0, 0, 1, 1);
        push(enc_2ri16(6'h17, 16'h0020, 5, 5), 15, 0, 0, 0, 1, 0, 0, 0, 1, 2);
        push(enc_2ri16(6'h18, 16'h0030, 5, 6), 15, 0, 0, 0, 1, 0, 0, 0, 1, 3);
        push(enc_2ri16(6'h19, 16'h8000, 5, 6), 15, 0, 0, 0, 1, 0, 0, 0, 1, 4);
        push(enc_2ri16(6'h1a, 16'h0044, 5, 6), 15, 0, 0, 0, 1, 0, 0, 0, 1, 5);
        push(enc_2ri16(6'h1b, 16'h0048, 5, 6), 15, 0, 0, 0, 1, 0, 0, 0, 1, 6);
        push(enc_2ri16(6'h14, 16'h1234, 31, 2), 15, 0, 0, 0, 0, 0, 0, 0, 1, 7);
        push(enc_2ri16(6'h15, 16'h0100, 0, 0), 0, 3, 1, 1, 0, 1, 0, 0, 1, 7);
        push(enc_2ri16(6'h13, 16'hfffe, 5, 1), 0, 3, 1, 1, 0, 1, 0, 0, 1, 7);
        // back-pressure
        push(enc_3r(17'h2b, 6, 5, 7), 7, 0, 0, 0, 1, 1, 0, 0, 0, 0);
        push(enc_2ri16(6'h16, 16'h0010, 5, 5), 15, 0, 0, 0, 1, 0, 0, 0, 0, 1);

        foreach (vectors[i])
            run_entry(vectors[i]);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* src.f */
isa_pkg.sv
pipe_pkg.sv
id_ctrl.sv
inst_decoder.sv
regfile.sv
operand_forward.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - id_ctrl.sv
  - inst_decoder.sv
  - regfile.sv
  - operand_forward.sv
  - branch_unit.sv
  - id_stage.sv
  - target: simulation
    files:
      - tb_id_stage.sv
